// File: hdl/game_pkg.sv
// game package: coordinate type, move commands, motion states and map constants

package game_pkg;

    typedef logic [10:0] coord_t;  // screen pixels

    typedef enum logic [2:0] {
        cmd_none,
        cmd_left,
        cmd_right,
        cmd_jump,
        cmd_up,
        cmd_down
    } move_cmd_t;

    typedef enum logic [3:0] {
        st_idle,
        st_idle_ladder,
        st_go_left,
        st_go_right,
        st_jump,
        st_fall,
        st_go_up,
        st_go_down,
        st_home
    } motion_state_t;

    // timing
    localparam int STEP_DIV    = 4;  // cycles per walk or climb pixel
    localparam int GRAVITY_DIV = 8;  // cycles per vertical update in the air

    localparam coord_t JUMP_HEIGHT = 11'd20;

    // screen and character
    localparam coord_t SCREEN_W = 11'd640;
    localparam coord_t CHAR_W   = 11'd16;

    // floors, y grows downward so floor 0 is the lowest
    localparam coord_t FLOOR_Y0 = 11'd440;
    localparam coord_t FLOOR_Y1 = 11'd320;
    localparam coord_t FLOOR_Y2 = 11'd200;

    localparam coord_t START_X = 11'd40;
    localparam coord_t START_Y = FLOOR_Y0;

    localparam coord_t FLOOR_END_X = 11'd480;  // floor 1 stops here

    // ladder 0 joins floors 0 and 1, ladder 1 joins floors 1 and 2
    localparam coord_t LADDER_X0 = 11'd200;
    localparam coord_t LADDER_X1 = 11'd400;
    localparam coord_t LADDER_W  = 11'd4;   // +/- tolerance around the column

endpackage

// File: hdl/input_decode.sv
// input decode: registers the button levels and issues one prioritized move command
`timescale 1ns/1ns

module input_decode
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      left,
    input  logic      right,
    input  logic      jump,
    input  logic      up,
    input  logic      down,
    input  logic      start_game,
    input  logic      animation,
    output move_cmd_t cmd
);

    logic      left_q, right_q, jump_q, up_q, down_q;
    logic      start_q, anim_q;
    move_cmd_t cmd_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            left_q  <= 1'b0;
            right_q <= 1'b0;
            jump_q  <= 1'b0;
            up_q    <= 1'b0;
            down_q  <= 1'b0;
            start_q <= 1'b0;
            anim_q  <= 1'b0;
            cmd     <= cmd_none;
        end else begin
            left_q  <= left;
            right_q <= right;
            jump_q  <= jump;
            up_q    <= up;
            down_q  <= down;
            start_q <= start_game;
            anim_q  <= animation;
            cmd     <= cmd_sel;
        end
    end

    always_comb begin
        if (!start_q || anim_q) begin  // game not running
            cmd_sel = cmd_none;
        end else if (left_q) begin
            cmd_sel = cmd_left;
        end else if (right_q) begin
            cmd_sel = cmd_right;
        end else if (jump_q) begin
            cmd_sel = cmd_jump;
        end else if (up_q) begin
            cmd_sel = cmd_up;  // ladder check is done by the movement block
        end else if (down_q) begin
            cmd_sel = cmd_down;
        end else begin
            cmd_sel = cmd_none;
        end
    end

endmodule

// File: hdl/map_lookup.sv
// map lookup: ladder presence, climb limits, floor end and landing row for a position
`timescale 1ns/1ns

module map_lookup
    import game_pkg::*;
(
    input  coord_t xpos,
    input  coord_t ypos,
    output logic   ladder,
    output coord_t limit_top,
    output coord_t limit_bottom,
    output logic   floor_end,
    output coord_t landing_y
);

    logic   near_l0, near_l1;
    logic   span_l0, span_l1;
    coord_t floor_row;

    // horizontal match within the tolerance
    always_comb begin
        near_l0 = (xpos + LADDER_W >= LADDER_X0) && (xpos <= LADDER_X0 + LADDER_W);
        near_l1 = (xpos + LADDER_W >= LADDER_X1) && (xpos <= LADDER_X1 + LADDER_W);
    end

    // vertical range each ladder covers, ends included
    always_comb begin
        span_l0 = (ypos >= FLOOR_Y1) && (ypos <= FLOOR_Y0);
        span_l1 = (ypos >= FLOOR_Y2) && (ypos <= FLOOR_Y1);
    end

    always_comb begin
        ladder = (near_l0 && span_l0) || (near_l1 && span_l1);
        if (near_l1 && span_l1) begin
            limit_top    = FLOOR_Y2;
            limit_bottom = FLOOR_Y1;
        end else begin
            limit_top    = FLOOR_Y1;  // ladder 0, also the default
            limit_bottom = FLOOR_Y0;
        end
    end

    // floor under the character
    always_comb begin
        if (ypos > FLOOR_Y1) begin
            floor_row = FLOOR_Y0;
        end else if (ypos > FLOOR_Y2) begin
            floor_row = FLOOR_Y1;
        end else begin
            floor_row = FLOOR_Y2;
        end
    end

    always_comb begin
        floor_end = (ypos == FLOOR_Y1) && (xpos > FLOOR_END_X);
        landing_y = floor_end ? FLOOR_Y0 : floor_row;  // drop to the bottom floor
    end

endmodule

// File: hdl/character_movement.sv
// character movement FSM for walking, jumping, falling and climbing ladders
`timescale 1ns/1ns

module character_movement
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  move_cmd_t cmd,
    input  logic      left,
    input  logic      right,
    input  logic      hit,
    input  logic      ladder,
    input  coord_t    limit_top,
    input  coord_t    limit_bottom,
    input  logic      floor_end,
    input  coord_t    landing_y,
    output coord_t    xpos,
    output coord_t    ypos
);

    motion_state_t state, state_nxt;
    logic [7:0]    cnt, cnt_nxt;
    coord_t        speed, speed_nxt;
    coord_t        land_y, land_y_nxt;
    logic          stuck, stuck_nxt;
    coord_t        xpos_nxt, ypos_nxt;
    logic          step_tick, step_last, steer_tick, gravity_tick;
    coord_t        peak_y;

    function automatic coord_t step_left(input coord_t x);
        return (x == '0) ? x : x - 11'd1;
    endfunction

    function automatic coord_t step_right(input coord_t x);
        return (x >= SCREEN_W - CHAR_W) ? x : x + 11'd1;
    endfunction

    // in-air steering from the live button levels
    function automatic coord_t steer(input coord_t x, input logic l, input logic r);
        coord_t res;
        if (l) begin
            res = step_left(x);
        end else if (r) begin
            res = step_right(x);
        end else begin
            res = x;
        end
        return res;
    endfunction

    always_comb begin
        step_tick    = (cnt == 8'(STEP_DIV));
        step_last    = (cnt == 8'(STEP_DIV + 1));
        steer_tick   = ((cnt % 8'(2 * STEP_DIV)) == '0);
        gravity_tick = ((cnt % 8'(GRAVITY_DIV)) == 8'(GRAVITY_DIV - 1));
        peak_y       = land_y - JUMP_HEIGHT;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            xpos  <= START_X;
            ypos  <= START_Y;
            cnt   <= '0;
            stuck <= 1'b0;
        end else begin
            state <= state_nxt;
            xpos  <= xpos_nxt;
            ypos  <= ypos_nxt;
            cnt   <= cnt_nxt;
            stuck <= stuck_nxt;
        end
    end

    // jump speed and landing row of the air states
    always_ff @(posedge clk) begin
        speed  <= speed_nxt;
        land_y <= land_y_nxt;
    end

    always_comb begin
        state_nxt  = state;
        xpos_nxt   = xpos;
        ypos_nxt   = ypos;
        cnt_nxt    = cnt + 8'd1;
        speed_nxt  = speed;
        land_y_nxt = land_y;
        stuck_nxt  = stuck;

        case (state)
            st_idle: begin
                cnt_nxt   = '0;
                stuck_nxt = 1'b0;
                if (floor_end) begin  // walked off floor 1
                    state_nxt  = st_fall;
                    land_y_nxt = landing_y;
                    speed_nxt  = 11'd1;
                end else if (cmd == cmd_left) begin
                    state_nxt = st_go_left;
                end else if (cmd == cmd_right) begin
                    state_nxt = st_go_right;
                end else if (cmd == cmd_jump) begin
                    state_nxt  = st_jump;
                    land_y_nxt = ypos;  // takeoff row
                    speed_nxt  = 11'd1;
                end else if (cmd == cmd_up && ladder) begin
                    state_nxt = st_go_up;
                end else if (cmd == cmd_down && ladder) begin
                    state_nxt = st_go_down;
                end
            end

            st_idle_ladder: begin
                cnt_nxt   = '0;
                stuck_nxt = 1'b0;
                if (cmd == cmd_up && ladder) begin
                    state_nxt = st_go_up;
                end else if (cmd == cmd_down && ladder) begin
                    state_nxt = st_go_down;
                end
            end

            st_go_left, st_go_right: begin
                if (step_tick) begin
                    xpos_nxt = (state == st_go_left) ? step_left(xpos) : step_right(xpos);
                end
                if (step_last) begin
                    state_nxt = st_idle;
                end
            end

            st_go_up: begin
                if (step_tick) begin
                    if (ypos <= limit_top) begin
                        stuck_nxt = 1'b1;  // top reached so no move
                    end else begin
                        ypos_nxt = ypos - 11'd1;
                    end
                end
                if (step_last) begin
                    state_nxt = stuck ? st_idle : st_idle_ladder;
                end
            end

            st_go_down: begin
                if (step_tick) begin
                    if (ypos >= limit_bottom) begin
                        stuck_nxt = 1'b1;
                    end else begin
                        ypos_nxt = ypos + 11'd1;
                    end
                end
                if (step_last) begin
                    state_nxt = stuck ? st_idle : st_idle_ladder;
                end
            end

            st_jump: begin
                if (steer_tick) begin
                    xpos_nxt = steer(xpos, left, right);
                end
                if (gravity_tick) begin
                    if (ypos <= peak_y + speed) begin  // clamp at the apex
                        ypos_nxt  = peak_y;
                        state_nxt = st_fall;
                        speed_nxt = 11'd1;
                    end else begin
                        ypos_nxt  = ypos - speed;
                        speed_nxt = speed + 11'd1;
                    end
                end
            end

            st_fall: begin
                if (steer_tick) begin
                    xpos_nxt = steer(xpos, left, right);
                end
                if (gravity_tick) begin
                    if (ypos + speed >= land_y) begin
                        ypos_nxt  = land_y;
                        state_nxt = st_idle;
                    end else begin
                        ypos_nxt  = ypos + speed;
                        speed_nxt = speed + 11'd1;
                    end
                end
            end

            st_home: begin
                xpos_nxt  = START_X;
                ypos_nxt  = START_Y;
                cnt_nxt   = '0;
                state_nxt = st_idle;
            end

            default: begin
                state_nxt = st_idle;
            end
        endcase

        if (hit) begin  // wins over any move
            state_nxt = st_home;
        end
    end

endmodule

// File: hdl/player_subsystem.sv
// player subsystem: joins command decode, map lookup and the movement FSM
`timescale 1ns/1ns

module player_subsystem
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   left,
    input  logic   right,
    input  logic   jump,
    input  logic   up,
    input  logic   down,
    input  logic   start_game,
    input  logic   animation,
    input  logic   hit,
    output coord_t xpos,
    output coord_t ypos
);

    move_cmd_t cmd;
    logic      ladder;
    logic      floor_end;
    coord_t    limit_top, limit_bottom, landing_y;

    input_decode u_input_decode (
        .clk        (clk),
        .rst        (rst),
        .left       (left),
        .right      (right),
        .jump       (jump),
        .up         (up),
        .down       (down),
        .start_game (start_game),
        .animation  (animation),
        .cmd        (cmd)
    );

    map_lookup u_map_lookup (
        .xpos         (xpos),
        .ypos         (ypos),
        .ladder       (ladder),
        .limit_top    (limit_top),
        .limit_bottom (limit_bottom),
        .floor_end    (floor_end),
        .landing_y    (landing_y)
    );

    character_movement u_character_movement (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .left         (left),   // live levels for steering in the air
        .right        (right),
        .hit          (hit),
        .ladder       (ladder),
        .limit_top    (limit_top),
        .limit_bottom (limit_bottom),
        .floor_end    (floor_end),
        .landing_y    (landing_y),
        .xpos         (xpos),
        .ypos         (ypos)
    );

endmodule

// File: testbench/clock_gen.sv
// clock and reset generator: 20 ns clock, reset held high for the first four cycles
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;  // released just after the fourth edge
    end

endmodule

// File: testbench/movement_checker.sv
// movement checker: reference rules for the player moves, compared against the DUT position
`timescale 1ns/1ns

module movement_checker
    import game_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   hit,
    input coord_t xpos,
    input coord_t ypos
);

    int         errors = 0;
    int         checks = 0;
    int         watch_errors = 0;
    int         watch_checks = 0;
    int         track_mode = 0;  // 0 off, 1 climb up, 2 climb down, 3 jump
    int         mode_q = 0;
    logic       track_bad = 1'b0;
    logic [1:0] hit_seen = 2'b00;
    coord_t     x_hold, y_prev, y_min;

    function automatic logic same(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: expected 0x%03h, got 0x%03h", name, exp, got);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic int error_count();
        return errors + watch_errors;
    endfunction

    function automatic int check_count();
        return checks + watch_checks;
    endfunction

    task automatic compare_pos(input coord_t exp_x, input coord_t exp_y);
        logic ok_x, ok_y;
        ok_x = same("xpos", xpos, exp_x);
        ok_y = same("ypos", ypos, exp_y);
        checks++;
        if (!(ok_x && ok_y)) begin
            errors++;
        end
    endtask

    // one pixel per step, clamped at both screen edges
    task automatic expect_walk(input coord_t x0, input coord_t y0, input logic go_left,
                               input int steps);
        int x;
        int i;
        x = int'(x0);
        for (i = 0; i < steps; i++) begin
            if (go_left) begin
                x = (x > 0) ? x - 1 : 0;
            end else begin
                x = (x < int'(SCREEN_W - CHAR_W)) ? x + 1 : x;
            end
        end
        compare_pos(coord_t'(x), y0);
    endtask

    task automatic expect_landed_past_end();
        checks++;
        if (!same("ypos", ypos, FLOOR_Y0)) begin
            errors++;
        end else if (xpos <= FLOOR_END_X) begin
            errors++;
            $display("character landed at x 0x%03h, not past the end of floor 1", xpos);
        end
    endtask

    task automatic track_begin(input int mode);
        track_mode = mode;
    endtask

    task automatic track_end();
        if (track_mode == 3) begin
            checks++;
            if (!same("min ypos", y_min, FLOOR_Y0 - JUMP_HEIGHT)) begin
                errors++;
            end
        end
        track_mode = 0;
    endtask

    always @(negedge clk) begin
        logic ok_x, ok_y;
        if (rst) begin
            hit_seen = 2'b00;
            mode_q   = 0;
        end else begin
            if (hit_seen[1]) begin  // hit sampled two edges ago
                ok_x = same("xpos", xpos, START_X);
                ok_y = same("ypos", ypos, START_Y);
                watch_checks++;
                if (!(ok_x && ok_y)) begin
                    watch_errors++;
                end
            end
            hit_seen = {hit_seen[0], hit};
            if (track_mode != mode_q) begin  // new tracking window
                x_hold    = xpos;
                y_prev    = ypos;
                y_min     = ypos;
                track_bad = 1'b0;
            end else if (track_mode != 0) begin
                if (ypos < y_min) begin
                    y_min = ypos;
                end
                if (!track_bad && xpos != x_hold) begin
                    track_bad = 1'b1;
                    watch_errors++;
                    $display("xpos moved from 0x%03h to 0x%03h during a vertical move",
                             x_hold, xpos);
                end else if (!track_bad && ((track_mode == 1 && ypos > y_prev) ||
                                            (track_mode == 2 && ypos < y_prev))) begin
                    track_bad = 1'b1;
                    watch_errors++;
                    $display("ypos turned back from 0x%03h to 0x%03h during the climb",
                             y_prev, ypos);
                end
                y_prev = ypos;
            end
            mode_q = track_mode;
        end
    end

endmodule

// File: testbench/tb_top.sv
// testbench top: random button stimulus and test sequence for the player subsystem
`timescale 1ns/1ns

module tb_top
    import game_pkg::*;
();

    logic        clk, rst;
    logic        left, right, jump, up, down;
    logic        start_game, animation, hit;
    coord_t      xpos, ypos;
    logic [31:0] lcg_state = 32'hd00d;
    int          tests_run = 0;
    int          tests_ok = 0;
    int          err_mark = 0;

    clock_gen clock_gen_inst (.clk(clk), .rst(rst));

    player_subsystem player_subsystem_inst (
        .clk        (clk),
        .rst        (rst),
        .left       (left),
        .right      (right),
        .jump       (jump),
        .up         (up),
        .down       (down),
        .start_game (start_game),
        .animation  (animation),
        .hit        (hit),
        .xpos       (xpos),
        .ypos       (ypos)
    );

    movement_checker movement_checker_inst (
        .clk  (clk),
        .rst  (rst),
        .hit  (hit),
        .xpos (xpos),
        .ypos (ypos)
    );

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]) % n;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic finish_run(input logic ok);
        if (ok) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic timeout(input string what);
        $display("timeout while waiting for %s", what);
        finish_run(1'b0);
    endtask

    task automatic release_all();
        left  = 1'b0;
        right = 1'b0;
        jump  = 1'b0;
        up    = 1'b0;
        down  = 1'b0;
        hit   = 1'b0;
    endtask

    // done when the position holds for two full step periods
    task automatic wait_still(input string what, input int limit);
        coord_t px, py;
        int     still, n;
        px = xpos;
        py = ypos;
        still = 0;
        n = 0;
        while (still < 2 * (STEP_DIV + 3)) begin
            next_cycle();
            n++;
            still = (xpos == px && ypos == py) ? still + 1 : 0;
            px = xpos;
            py = ypos;
            if (n > limit) begin
                timeout(what);
            end
        end
    endtask

    task automatic wait_ypos(input string what, input coord_t y, input logic at, input int limit);
        int n;
        n = 0;
        while ((ypos == y) != at) begin
            next_cycle();
            n++;
            if (n > limit) begin
                timeout(what);
            end
        end
    endtask

    task automatic pulse_hit();
        int n;
        n = 0;
        release_all();
        hit = 1'b1;
        next_cycle();
        hit = 1'b0;
        while (xpos != START_X || ypos != START_Y) begin
            next_cycle();
            n++;
            if (n > 4) begin
                timeout("return to the home position");
            end
        end
        wait_still("settling at home", 100);
    endtask

    task automatic go_home();
        release_all();
        wait_still("motion to stop", 1000);
        pulse_hit();
    endtask

    // a held button gives one pixel per STEP_DIV+3 cycles
    task automatic walk(input logic go_left, input int steps);
        left  = go_left;
        right = !go_left;
        repeat (steps * (STEP_DIV + 3)) next_cycle();
        release_all();
        wait_still("walk to stop", 100);
    endtask

    task automatic climb(input logic go_up);
        up   = go_up;
        down = !go_up;
        wait_still("climb to reach its limit", 3000);
        release_all();
        wait_still("climb to stop", 100);
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = movement_checker_inst.error_count() - err_mark;
        tests_run++;
        if (errs == 0) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", tests_run, name, errs);
        end
        err_mark = movement_checker_inst.error_count();
    endtask

    initial begin
        int   i, n, steps, kind, delay;
        logic go_left;
        release_all();
        start_game = 1'b0;
        animation  = 1'b0;
        n = 0;
        while (rst) begin
            next_cycle();
            n++;
            if (n > 20) begin
                timeout("reset release");
            end
        end

        for (i = 0; i < 60; i++) begin
            start_game = (i >= 30);  // second half runs an animation instead
            animation  = (i >= 30);
            left  = rand_below(2) != 0;
            right = rand_below(2) != 0;
            jump  = rand_below(2) != 0;
            up    = rand_below(2) != 0;
            down  = rand_below(2) != 0;
            next_cycle();
            movement_checker_inst.compare_pos(START_X, START_Y);
        end
        release_all();
        animation = 1'b0;
        wait_still("gate to settle", 100);
        end_test("gate");

        for (i = 0; i < 3; i++) begin
            go_home();
            go_left = rand_below(2) != 0;
            steps = 1 + rand_below(60);
            walk(go_left, steps);
            movement_checker_inst.expect_walk(START_X, START_Y, go_left, steps);
        end
        end_test("walk");

        go_home();
        movement_checker_inst.track_begin(3);
        jump = 1'b1;
        next_cycle();
        jump = 1'b0;
        wait_ypos("takeoff", FLOOR_Y0, 1'b0, 50);
        wait_ypos("landing", FLOOR_Y0, 1'b1, 400);
        wait_still("jump to settle", 100);
        movement_checker_inst.track_end();
        movement_checker_inst.compare_pos(START_X, FLOOR_Y0);
        end_test("jump");

        go_home();
        walk(1'b0, int'(LADDER_X0 - START_X));
        movement_checker_inst.compare_pos(LADDER_X0, FLOOR_Y0);
        movement_checker_inst.track_begin(1);
        climb(1'b1);
        movement_checker_inst.track_end();
        movement_checker_inst.compare_pos(LADDER_X0, FLOOR_Y1);
        movement_checker_inst.track_begin(2);
        climb(1'b0);
        movement_checker_inst.track_end();
        movement_checker_inst.compare_pos(LADDER_X0, FLOOR_Y0);
        end_test("ladder");

        go_home();
        walk(1'b0, int'(LADDER_X0 - START_X));
        climb(1'b1);
        movement_checker_inst.compare_pos(LADDER_X0, FLOOR_Y1);
        right = 1'b1;
        wait_ypos("fall off floor 1", FLOOR_Y1, 1'b0, 3000);
        right = 1'b0;
        wait_still("fall to settle", 400);
        movement_checker_inst.expect_landed_past_end();
        end_test("floor end");

        for (i = 0; i < 6; i++) begin
            go_home();
            kind  = rand_below(3);
            delay = 1 + rand_below(60);
            left  = (kind == 1);
            right = (kind == 0);
            jump  = (kind == 2);
            repeat (delay) next_cycle();
            pulse_hit();  // checker compares two cycles after the hit
        end
        end_test("hit");

        $display("tests run %0d, passed %0d, checks %0d, errors %0d", tests_run, tests_ok,
                 movement_checker_inst.check_count(), movement_checker_inst.error_count());
        finish_run(tests_ok == tests_run && movement_checker_inst.error_count() == 0);
    end

endmodule

// File: files.f
hdl/game_pkg.sv
hdl/input_decode.sv
hdl/map_lookup.sv
hdl/character_movement.sv
hdl/player_subsystem.sv
testbench/clock_gen.sv
testbench/movement_checker.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the player subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
